// ==== Makefile ====
# Verilator build and run for the stick smoother testbench

SRCS := $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vstick_smoother_tb: stick_smoother.f $(SRCS)
	verilator --binary --timing --assert -f stick_smoother.f \
		--top-module stick_smoother_tb -Mdir obj_dir

run: obj_dir/Vstick_smoother_tb
	./obj_dir/Vstick_smoother_tb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src/change_limiter.sv ====
// one channel of stick smoothing, output is the mean of the last 32 accepted samples
// an idle sample (below IDLE_LIMIT) wipes the history so the output drops to 0
// a new start is expected only while WAITING, the frame latch guarantees this
// fixed latency: complete is high 4 cycles after start is seen
`timescale 1ns/1ps

module change_limiter
	import drone_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	limiter_if.limiter lim
);

	limiter_state_t state;
	limiter_state_t next_state;

	// sample taken from value_in in BUFFERING
	rec_val_t sample;
	logic sample_idle;

	// circular history and its running sum
	rec_val_t history [HIST_DEPTH];
	hist_ptr_t wr_ptr;
	sum_t hist_sum;
	sum_t next_sum;

	// state register
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= WAITING;
		else
			state <= next_state;
	end

	// one state per cycle once started
	always_comb begin
		case (state)
			WAITING: begin
				if (lim.start)
					next_state = BUFFERING;
				else
					next_state = WAITING;
			end
			BUFFERING: begin
				next_state = ADDING;
			end
			ADDING: begin
				next_state = AVERAGING;
			end
			AVERAGING: begin
				next_state = COMPLETE;
			end
			COMPLETE: begin
				next_state = WAITING;
			end
			default: begin
				next_state = WAITING;
			end
		endcase
	end

	// latch the channel value for this frame
	always_ff @(posedge us_clk) begin
		if (state == BUFFERING)
			sample <= lim.value_in;
	end

	assign sample_idle = (sample < IDLE_LIMIT);

	// evict the oldest entry and add the newest one
	// the oldest entry is the one the write pointer is about to overwrite
	assign next_sum = hist_sum - sum_t'(history[wr_ptr]) + sum_t'(sample);

	// history update, once per frame in ADDING
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < HIST_DEPTH; i++)
				history[i] <= '0;
			hist_sum <= '0;
			wr_ptr <= '0;
		end else if (state == ADDING) begin
			if (sample_idle) begin
				// power off, forget everything seen so far
				for (int i = 0; i < HIST_DEPTH; i++)
					history[i] <= '0;
				hist_sum <= '0;
			end else begin
				history[wr_ptr] <= sample;
				hist_sum <= next_sum;
				// wraps at HIST_DEPTH
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// average is the sum over a power of two depth, max 255 so it fits rec_val_t
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			lim.value_out <= '0;
		else if (state == AVERAGING)
			lim.value_out <= rec_val_t'(hist_sum >> HIST_LOG2);
	end

	// status decoded straight from the state
	assign lim.active = (state == BUFFERING) || (state == ADDING) || (state == AVERAGING);
	assign lim.complete = (state == COMPLETE);

endmodule

// ==== src/drone_pkg.sv ====
// shared widths, limits and types for the stick smoother
// channel order in a frame is throttle, yaw, roll, pitch with throttle at index 0
// history depth and idle threshold are fixed here and apply to every channel
// history depth must stay a power of two since the average is a plain shift
package drone_pkg;

	// width of one receiver or smoothed stick value
	localparam int REC_VAL_W = 8;

	// channels carried in one receiver frame
	localparam int NUM_CHANNELS = 4;

	// 32 samples of history, 0.64 s at the nominal 20 ms frame rate
	localparam int HIST_LOG2 = 5;
	localparam int HIST_DEPTH = 1 << HIST_LOG2;

	// running sum must hold HIST_DEPTH full scale samples, 32 x 255 = 8160
	localparam int SUM_W = REC_VAL_W + HIST_LOG2;

	// one stick value, raw or smoothed
	typedef logic [REC_VAL_W-1:0] rec_val_t;

	// running history sum of one channel
	typedef logic [SUM_W-1:0] sum_t;

	// write pointer into the circular history
	typedef logic [HIST_LOG2-1:0] hist_ptr_t;

	// whole frame, 32 bits, index 0 is throttle
	typedef rec_val_t [NUM_CHANNELS-1:0] rc_frame_t;

	// samples strictly below this are idle and mean power off
	localparam rec_val_t IDLE_LIMIT = 8'd10;

	// one-hot limiter states, one state per cycle after start
	typedef enum logic [4:0] {
		WAITING   = 5'b00001,
		BUFFERING = 5'b00010,
		ADDING    = 5'b00100,
		AVERAGING = 5'b01000,
		COMPLETE  = 5'b10000
	} limiter_state_t;

endpackage

// ==== src/limiter_if.sv ====
// link between the frame latch, one change limiter and the collector
// start and complete are single cycle pulses, active is a level
// value_in stays stable from start until the next accepted frame
`timescale 1ns/1ps

interface limiter_if
	import drone_pkg::*;
();

	// feeder side
	logic start;
	rec_val_t value_in;

	// limiter side, value_out is registered
	rec_val_t value_out;
	logic active;
	logic complete;

	// frame latch drives the sample and the start pulse
	modport feeder (output start, output value_in, input active);

	// limiter consumes the sample and reports its result
	modport limiter (
		input start,
		input value_in,
		output value_out,
		output active,
		output complete
	);

	// collector only sees the result and the done pulse
	modport drain (input value_out, input complete);

endinterface

// ==== src/motor_update_collector.sv ====
// waits for every channel to report complete, then publishes the whole smoothed frame
// channels may finish in different cycles, a done flag is kept per channel
// rc_out holds its value until the next frame is published
`timescale 1ns/1ps

module motor_update_collector
	import drone_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	limiter_if.drain lim [NUM_CHANNELS],
	output rc_frame_t rc_out,
	output logic frame_done
);

	// per-channel flags for channels already finished this frame
	logic [NUM_CHANNELS-1:0] done_q;
	// complete pulses seen this cycle
	logic [NUM_CHANNELS-1:0] complete_vec;
	// current results gathered from the limiters
	rc_frame_t value_vec;
	// every channel done, counting this cycle's pulses
	logic all_done;

	// flatten the interface array
	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_drain
		assign complete_vec[ch] = lim[ch].complete;
		assign value_vec[ch] = lim[ch].value_out;
	end

	// last channel's pulse counts directly, no extra cycle for the flag
	assign all_done = &(done_q | complete_vec);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			done_q <= '0;
			rc_out <= '0;
			frame_done <= 1'b0;
		end else if (all_done) begin
			// publish and start collecting the next frame
			rc_out <= value_vec;
			frame_done <= 1'b1;
			done_q <= '0;
		end else begin
			done_q <= done_q | complete_vec;
			frame_done <= 1'b0;
		end
	end

endmodule

// ==== src/rc_frame_latch.sv ====
// captures one receiver frame per accepted frame_strobe and starts all limiters together
// strobes that arrive while a frame is in flight are dropped, there is no queue
// busy runs from the cycle after start until frame_done has been seen
`timescale 1ns/1ps

module rc_frame_latch
	import drone_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	input logic frame_strobe,
	input rc_frame_t rc_in,
	input logic frame_done,
	output logic busy,
	limiter_if.feeder lim [NUM_CHANNELS]
);

	// common start pulse for every channel
	logic start_q;
	// strobe taken only when no frame is running
	logic accept;
	// frame held for the limiters until the next accepted strobe
	rc_frame_t frame_q;

	// start_q covers the one cycle before busy rises
	assign accept = frame_strobe && !busy && !start_q;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_q <= 1'b0;
			busy <= 1'b0;
		end else begin
			start_q <= accept;
			// busy rises with start and falls once the collector publishes
			if (start_q)
				busy <= 1'b1;
			else if (frame_done)
				busy <= 1'b0;
		end
	end

	// payload only, loaded on acceptance
	always_ff @(posedge us_clk) begin
		if (accept)
			frame_q <= rc_in;
	end

	// fan out the frame, one byte per limiter
	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_feed
		assign lim[ch].start = start_q;
		assign lim[ch].value_in = frame_q[ch];
	end

endmodule

// ==== src/stick_smoother_top.sv ====
// stick smoother top level, four channels smoothed over 32 frames each
// frame_done pulses 6 cycles after an accepted frame_strobe
// strobes while busy are dropped, rc_out holds between frames
`timescale 1ns/1ps

module stick_smoother_top
	import drone_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	input logic frame_strobe,
	input rc_frame_t rc_in,
	output rc_frame_t rc_out,
	output logic frame_done,
	output logic busy
);

	// one link per channel, shared by latch, limiter and collector
	limiter_if lim_bus [NUM_CHANNELS] ();

	// frame capture and start fan-out, busy released by frame_done
	rc_frame_latch i_latch (
		.us_clk(us_clk),
		.resetn(resetn),
		.frame_strobe(frame_strobe),
		.rc_in(rc_in),
		.frame_done(frame_done),
		.busy(busy),
		.lim(lim_bus)
	);

	// identical limiter per channel
	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
		change_limiter i_limiter (
			.us_clk(us_clk),
			.resetn(resetn),
			.lim(lim_bus[ch])
		);
	end

	// joins the channels back into one frame
	motor_update_collector i_collector (
		.us_clk(us_clk),
		.resetn(resetn),
		.lim(lim_bus),
		.rc_out(rc_out),
		.frame_done(frame_done)
	);

endmodule

// ==== stick_smoother.f ====
src/drone_pkg.sv
src/limiter_if.sv
src/rc_frame_latch.sv
src/change_limiter.sv
src/motor_update_collector.sv
src/stick_smoother_top.sv
test/stick_smoother_properties.sv
test/stick_smoother_tb.sv

// ==== test/stick_smoother_properties.sv ====
// concurrent checks bound into stick_smoother_top
// limiter status is taken from the interface array, one bit per channel
// latency is counted from the edge that samples an accepted frame_strobe
`timescale 1ns/1ps

module stick_smoother_properties
	import drone_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	input logic frame_strobe,
	input logic busy,
	input logic start,
	input logic frame_done,
	input logic [NUM_CHANNELS-1:0] active,
	input logic [NUM_CHANNELS-1:0] complete
);

	// frame_done is a single cycle pulse
	a_done_pulse: assert property (@(posedge us_clk) disable iff (!resetn)
		frame_done |=> !frame_done)
		else $error("frame_done held longer than one cycle");

	// accepted strobe to frame_done, fixed pipeline of 6 cycles
	a_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		(frame_strobe && !busy && !start) |-> ##6 frame_done)
		else $error("frame_done not 6 cycles after accepted strobe");

	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chk
		// complete lasts one cycle on every channel
		a_complete_pulse: assert property (@(posedge us_clk) disable iff (!resetn)
			complete[ch] |=> !complete[ch])
			else $error("complete held longer than one cycle on channel %0d", ch);

		// a limiter is never active while it reports complete
		a_active_excl: assert property (@(posedge us_clk) disable iff (!resetn)
			!(active[ch] && complete[ch]))
			else $error("active and complete high together on channel %0d", ch);
	end

endmodule

bind stick_smoother_top stick_smoother_properties i_props (
	.us_clk(us_clk),
	.resetn(resetn),
	.frame_strobe(frame_strobe),
	.busy(busy),
	.start(i_latch.start_q),
	.frame_done(frame_done),
	.active({lim_bus[3].active, lim_bus[2].active, lim_bus[1].active, lim_bus[0].active}),
	.complete({lim_bus[3].complete, lim_bus[2].complete, lim_bus[1].complete,
		lim_bus[0].complete})
);

// ==== test/stick_smoother_tb.sv ====
// trace driven testbench for stick_smoother_top, run from the project root
// trace lines repeat a frame rep times, expected values are checked on the last one
// gap > 0 injects an idle frame_strobe that many cycles after the real one, it must be dropped
// a reference model keeps its own 32-entry histories and re-sums them every frame
`timescale 1ns/1ps

module stick_smoother_tb;
	import drone_pkg::*;

	logic us_clk;
	logic resetn;
	logic frame_strobe;
	rc_frame_t rc_in;
	rc_frame_t rc_out;
	logic frame_done;
	logic busy;

	int cycles = 0;
	int cycle_limit = 100000;
	int errors = 0;
	int checks = 0;
	int tests_done = 0;

	// trace contents, inputs and expected values flattened four per line
	int tr_test[$];
	int tr_rep[$];
	int tr_gap[$];
	int tr_chk[$];
	int tr_in[$];
	int tr_exp[$];

	// reference model state
	int hist[NUM_CHANNELS][HIST_DEPTH];
	int wptr[NUM_CHANNELS];
	int model_out[NUM_CHANNELS];
	rc_frame_t last_out;

	stick_smoother_top i_dut (
		.us_clk(us_clk),
		.resetn(resetn),
		.frame_strobe(frame_strobe),
		.rc_in(rc_in),
		.rc_out(rc_out),
		.frame_done(frame_done),
		.busy(busy)
	);

	always #50 us_clk = ~us_clk;

	// run limit from the trace length
	always @(posedge us_clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic load_trace();
		int fd;
		int n;
		int f[12];
		string line;
		fd = $fopen("test/stick_smoother_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file test/stick_smoother_trace.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
				f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
			// comment and blank lines give no fields
			if (n == 12) begin
				tr_test.push_back(f[0]);
				tr_rep.push_back(f[1]);
				tr_gap.push_back(f[2]);
				tr_chk.push_back(f[3]);
				for (int ch = 0; ch < 4; ch++) begin
					tr_in.push_back(f[4 + ch]);
					tr_exp.push_back(f[8 + ch]);
				end
			end
		end
		$fclose(fd);
		if (tr_test.size() == 0) begin
			$display("the trace file holds no frames");
			errors++;
		end
	endtask

	// one accepted sample on one channel, idle clears the history
	function automatic int model_step(input int ch, input int v);
		int sum;
		sum = 0;
		if (v < int'(IDLE_LIMIT)) begin
			for (int i = 0; i < HIST_DEPTH; i++)
				hist[ch][i] = 0;
			return 0;
		end
		hist[ch][wptr[ch]] = v;
		wptr[ch] = (wptr[ch] + 1) % HIST_DEPTH;
		for (int i = 0; i < HIST_DEPTH; i++)
			sum += hist[ch][i];
		return sum / HIST_DEPTH;
	endfunction

	task automatic run_frame(input int idx, input bit last_rep);
		int c0;
		@(posedge us_clk);
		frame_strobe <= 1'b1;
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
			rc_in[ch] <= rec_val_t'(tr_in[idx * 4 + ch]);
		@(posedge us_clk);
		frame_strobe <= 1'b0;
		@(negedge us_clk);
		// cycle count just after the edge that sampled the strobe
		c0 = cycles;
		if (tr_gap[idx] > 0) begin
			repeat (tr_gap[idx] - 1) @(posedge us_clk);
			frame_strobe <= 1'b1;
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
				rc_in[ch] <= 8'd5;
			@(posedge us_clk);
			frame_strobe <= 1'b0;
			@(negedge us_clk);
		end
		while (frame_done !== 1'b1 && (cycles - c0) < 20)
			@(negedge us_clk);
		if (frame_done !== 1'b1) begin
			$display("frame_done never came for trace line %0d", idx);
			errors++;
			return;
		end
		check_value("frame_done latency", cycles - c0 + 1, 6);
		// busy covers the frame until frame_done falls
		check_value("busy during frame", int'(busy), 1);
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			model_out[ch] = model_step(ch, tr_in[idx * 4 + ch]);
			check_value($sformatf("rc_out[%0d]", ch), int'(rc_out[ch]), model_out[ch]);
			if (last_rep && tr_chk[idx] != 0)
				check_value($sformatf("model vs trace ch %0d", ch), model_out[ch],
					tr_exp[idx * 4 + ch]);
		end
		last_out = rc_out;
		// outputs hold until the next frame, strobes land 10 cycles apart
		while ((cycles - c0) < 8) begin
			@(negedge us_clk);
			check_value("rc_out hold", int'(rc_out == last_out), 1);
			check_value("frame_done idle", int'(frame_done), 0);
			check_value("busy after frame", int'(busy), 0);
		end
	endtask

	task automatic report_test(input int num, input int frames, input int err0);
		$display("test %0d finished: %0d frames, %0d errors", num, frames, errors - err0);
		tests_done++;
	endtask

	initial begin
		int frames;
		int cur;
		int tframes;
		int err0;
		us_clk = 1'b0;
		resetn = 1'b0;
		frame_strobe = 1'b0;
		rc_in = '0;
		load_trace();
		frames = 0;
		foreach (tr_rep[i])
			frames += tr_rep[i];
		cycle_limit = frames * 12 + 200;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			wptr[ch] = 0;
			for (int i = 0; i < HIST_DEPTH; i++)
				hist[ch][i] = 0;
		end
		repeat (8) @(posedge us_clk);
		resetn <= 1'b1;

		// test 1, quiet after reset
		err0 = errors;
		repeat (6) begin
			@(negedge us_clk);
			check_value("rc_out after reset", int'(rc_out), 0);
			check_value("frame_done after reset", int'(frame_done), 0);
			check_value("busy after reset", int'(busy), 0);
		end
		report_test(1, 0, err0);

		cur = -1;
		tframes = 0;
		foreach (tr_test[i]) begin
			if (tr_test[i] != cur) begin
				if (cur >= 0)
					report_test(cur, tframes, err0);
				cur = tr_test[i];
				tframes = 0;
				err0 = errors;
			end
			for (int r = 0; r < tr_rep[i]; r++) begin
				run_frame(i, r == tr_rep[i] - 1);
				tframes++;
			end
		end
		if (cur >= 0)
			report_test(cur, tframes, err0);

		$display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== test/stick_smoother_trace.txt ====
# test rep gap chk, then inputs throttle yaw roll pitch, then expected throttle yaw roll pitch
# chk 0 means the expected columns are don't care, gap > 0 adds a dropped idle strobe
# test 2: step up to 200 for 32 frames
2 1 0 1 200 200 200 200 6 6 6 6
2 30 0 0 200 200 200 200 0 0 0 0
2 1 0 1 200 200 200 200 200 200 200 200
# test 2: step down to 100
2 1 0 1 100 100 100 100 196 196 196 196
2 14 0 0 100 100 100 100 0 0 0 0
2 1 0 1 100 100 100 100 150 150 150 150
2 15 0 0 100 100 100 100 0 0 0 0
2 1 0 1 100 100 100 100 100 100 100 100
# test 3: idle throttle clears only its own history
3 1 0 1 5 100 100 100 0 100 100 100
3 1 0 1 160 100 100 100 5 100 100 100
3 1 0 1 160 100 100 100 10 100 100 100
# test 4: separate ramps on yaw, roll and pitch
4 1 0 1 160 132 68 100 15 101 99 100
4 1 0 1 160 164 36 228 20 103 97 104
4 1 0 1 160 196 20 100 25 106 94 104
# test 5: latency and hold between frames
5 1 0 1 160 196 20 100 30 109 92 104
5 1 0 1 160 196 20 100 35 112 89 104
# test 6: idle strobe 3 cycles after each frame must be dropped
6 1 3 1 160 196 20 100 40 115 87 104
6 1 3 1 160 196 20 100 45 118 84 104
